//--- source/cpu_pkg.sv
`default_nettype none

package cpu_pkg;

    localparam int XLEN = 32;

    typedef logic [XLEN-1:0] word_t;
    typedef logic [4:0]      reg_idx_t;

    // instruction class carried from execute to memory stage
    typedef enum logic [2:0] {
        OP_NOP,
        OP_ADD,
        OP_ADDI,
        OP_LD,
        OP_ST
    } op_e;

    // ==================================================
    // opcodes
    // ==================================================

    // 3R format, opcode in bits 31..15
    localparam logic [16:0] OPC_ADD_W  = 17'h00020;

    // 2RI12 format, opcode in bits 31..22
    localparam logic [9:0]  OPC_ADDI_W = 10'h00A;
    localparam logic [9:0]  OPC_LD_W   = 10'h0A2;
    // st.w uses rd as the data source
    localparam logic [9:0]  OPC_ST_W   = 10'h0A6;

endpackage

`default_nettype wire

//--- source/reg_file.sv
`timescale 1ns/1ps
`default_nettype none

module reg_file (
    input  wire logic             clk,
    input  wire logic             rst_n_i,
    input  wire cpu_pkg::reg_idx_t ra_i,
    input  wire cpu_pkg::reg_idx_t rb_i,
    input  wire cpu_pkg::reg_idx_t rc_i,
    output cpu_pkg::word_t        ra_data_o,
    output cpu_pkg::word_t        rb_data_o,
    output cpu_pkg::word_t        rc_data_o,
    input  wire logic             we_i,
    input  wire cpu_pkg::reg_idx_t wnum_i,
    input  wire cpu_pkg::word_t   wdata_i
);

    import cpu_pkg::*;

    word_t regs [32];

    // write-first, r0 reads zero
    function automatic word_t read_port(input reg_idx_t idx);
        word_t val;
        if (idx == '0)
            val = '0;
        else if (we_i && wnum_i == idx)
            val = wdata_i;
        else
            val = regs[idx];
        return val;
    endfunction

    always_comb begin
        ra_data_o = read_port(ra_i);
        rb_data_o = read_port(rb_i);
        rc_data_o = read_port(rc_i);
    end

    always_ff @(posedge clk) begin
        if (rst_n_i && we_i && wnum_i != '0) begin
            regs[wnum_i] <= wdata_i;
        end
    end

endmodule

`default_nettype wire

//--- source/fetch_unit.sv
`timescale 1ns/1ps
`default_nettype none

module fetch_unit #(
    parameter cpu_pkg::word_t RESET_PC = '0
) (
    input  wire logic           clk,
    input  wire logic           rst_n_i,
    // instruction bus
    output logic                ibus_req_o,
    output cpu_pkg::word_t      ibus_addr_o,
    input  wire logic           ibus_gnt_i,
    input  wire logic           ibus_rvalid_i,
    input  wire cpu_pkg::word_t ibus_rdata_i,
    // to execute
    input  wire logic           ex_ready_i,
    output logic                if_valid_o,
    output cpu_pkg::word_t      if_inst_o,
    output cpu_pkg::word_t      if_pc_o
);

    import cpu_pkg::*;

    logic  req_q;
    logic  wait_q;
    logic  valid_q;
    logic  take;
    word_t pc_q;
    word_t inst_q;
    word_t ipc_q;

    assign take = valid_q && ex_ready_i;

    // ==================================================
    // request sequencing
    // ==================================================
    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            req_q   <= 1'b0;
            wait_q  <= 1'b0;
            valid_q <= 1'b0;
            pc_q    <= RESET_PC;
        end else begin
            if (req_q && ibus_gnt_i) begin
                req_q  <= 1'b0;
                wait_q <= 1'b1;
                pc_q   <= pc_q + 32'd4;
            end else if (!req_q && !wait_q && (!valid_q || take)) begin
                // holding register empty or leaving this cycle
                req_q <= 1'b1;
            end

            if (ibus_rvalid_i) begin
                wait_q  <= 1'b0;
                valid_q <= 1'b1;
            end else if (take) begin
                valid_q <= 1'b0;
            end
        end
    end

    // holding register
    always_ff @(posedge clk) begin
        if (ibus_rvalid_i) begin
            inst_q <= ibus_rdata_i;
            // pc already advanced at acceptance
            ipc_q  <= pc_q - 32'd4;
        end
    end

    assign ibus_req_o  = req_q;
    assign ibus_addr_o = pc_q;

    assign if_valid_o = valid_q;
    assign if_inst_o  = inst_q;
    assign if_pc_o    = ipc_q;

endmodule

`default_nettype wire

//--- source/exec_unit.sv
`timescale 1ns/1ps
`default_nettype none

module exec_unit (
    input  wire logic              clk,
    input  wire logic              rst_n_i,
    // from fetch
    input  wire logic              if_valid_i,
    input  wire cpu_pkg::word_t    if_inst_i,
    input  wire cpu_pkg::word_t    if_pc_i,
    output logic                   ex_ready_o,
    // register file read
    output cpu_pkg::reg_idx_t      ra_o,
    output cpu_pkg::reg_idx_t      rb_o,
    output cpu_pkg::reg_idx_t      rc_o,
    input  wire cpu_pkg::word_t    ra_data_i,
    input  wire cpu_pkg::word_t    rb_data_i,
    input  wire cpu_pkg::word_t    rc_data_i,
    // from memory stage
    input  wire logic              mem_busy_i,
    input  wire logic              mem_dst_valid_i,
    input  wire cpu_pkg::reg_idx_t mem_dst_i,
    // memory stage register
    output logic                   ex_valid_o,
    output cpu_pkg::op_e           ex_op_o,
    output cpu_pkg::reg_idx_t      ex_rd_o,
    output cpu_pkg::word_t         ex_result_o,
    output cpu_pkg::word_t         ex_wdata_o,
    output cpu_pkg::word_t         ex_pc_o,
    output cpu_pkg::word_t         ex_inst_o
);

    import cpu_pkg::*;

    op_e      op;
    reg_idx_t rj;
    reg_idx_t rk;
    reg_idx_t rd;
    word_t    imm;
    word_t    result;
    logic     use_rk;
    logic     use_rd;
    logic     hazard;

    assign rd  = if_inst_i[4:0];
    assign rj  = if_inst_i[9:5];
    assign rk  = if_inst_i[14:10];
    assign imm = {{20{if_inst_i[21]}}, if_inst_i[21:10]};

    // ==================================================
    // decode
    // ==================================================
    always_comb begin
        op = OP_NOP;
        if (if_inst_i[31:15] == OPC_ADD_W) begin
            op = OP_ADD;
        end else begin
            case (if_inst_i[31:22])
                OPC_ADDI_W: op = OP_ADDI;
                OPC_LD_W:   op = OP_LD;
                OPC_ST_W:   op = OP_ST;
                default:    op = OP_NOP;
            endcase
        end
    end

    assign ra_o = rj;
    assign rb_o = rk;
    assign rc_o = rd;

    assign use_rk = (op == OP_ADD);
    assign use_rd = (op == OP_ST);

    // raw check against the instruction in the memory stage only
    always_comb begin
        hazard = 1'b0;
        if (if_valid_i && op != OP_NOP && mem_dst_valid_i && mem_dst_i != '0) begin
            hazard = (rj == mem_dst_i)
                  || (use_rk && rk == mem_dst_i)
                  || (use_rd && rd == mem_dst_i);
        end
    end

    assign ex_ready_o = !mem_busy_i && !hazard;

    // sum for alu ops, address for ld/st
    assign result = ra_data_i + (use_rk ? rb_data_i : imm);

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            ex_valid_o <= 1'b0;
        end else if (!mem_busy_i) begin
            // bubble on hazard
            ex_valid_o <= if_valid_i && !hazard;
        end
    end

    always_ff @(posedge clk) begin
        if (!mem_busy_i) begin
            ex_op_o     <= op;
            ex_rd_o     <= rd;
            ex_result_o <= result;
            ex_wdata_o  <= rc_data_i;
            ex_pc_o     <= if_pc_i;
            ex_inst_o   <= if_inst_i;
        end
    end

endmodule

`default_nettype wire

//--- source/mem_unit.sv
`timescale 1ns/1ps
`default_nettype none

module mem_unit (
    input  wire logic              clk,
    input  wire logic              rst_n_i,
    // memory stage register
    input  wire logic              ex_valid_i,
    input  wire cpu_pkg::op_e      ex_op_i,
    input  wire cpu_pkg::reg_idx_t ex_rd_i,
    input  wire cpu_pkg::word_t    ex_result_i,
    input  wire cpu_pkg::word_t    ex_wdata_i,
    input  wire cpu_pkg::word_t    ex_pc_i,
    input  wire cpu_pkg::word_t    ex_inst_i,
    // stall chain and hazard info
    output logic                   mem_busy_o,
    output logic                   mem_dst_valid_o,
    output cpu_pkg::reg_idx_t      mem_dst_o,
    // data bus
    output logic                   dbus_req_o,
    output logic                   dbus_we_o,
    output cpu_pkg::word_t         dbus_addr_o,
    output cpu_pkg::word_t         dbus_wdata_o,
    input  wire logic              dbus_gnt_i,
    input  wire logic              dbus_rvalid_i,
    input  wire cpu_pkg::word_t    dbus_rdata_i,
    // register write
    output logic                   rf_we_o,
    output cpu_pkg::reg_idx_t      rf_wnum_o,
    output cpu_pkg::word_t         rf_wdata_o,
    // debug
    output logic                   debug_wb_valid_o,
    output logic                   debug_wb_we_o,
    output cpu_pkg::word_t         debug_wb_pc_o,
    output cpu_pkg::reg_idx_t      debug_wb_wnum_o,
    output cpu_pkg::word_t         debug_wb_wdata_o,
    output cpu_pkg::word_t         debug_wb_inst_o
);

    import cpu_pkg::*;

    logic     is_mem;
    logic     writes_rd;
    logic     done;
    logic     issued_q;
    logic     wb_valid_q;
    logic     wb_we_q;
    reg_idx_t wb_wnum_q;
    word_t    wb_wdata_q;
    word_t    wb_pc_q;
    word_t    wb_inst_q;

    assign is_mem    = (ex_op_i == OP_LD) || (ex_op_i == OP_ST);
    assign writes_rd = (ex_op_i == OP_ADD) || (ex_op_i == OP_ADDI) || (ex_op_i == OP_LD);

    // alu ops leave at once, ld/st wait for their response
    assign done       = ex_valid_i && (!is_mem || (issued_q && dbus_rvalid_i));
    assign mem_busy_o = ex_valid_i && !done;

    assign mem_dst_valid_o = ex_valid_i && writes_rd;
    assign mem_dst_o       = ex_rd_i;

    assign dbus_req_o   = ex_valid_i && is_mem && !issued_q;
    assign dbus_we_o    = (ex_op_i == OP_ST);
    assign dbus_addr_o  = ex_result_i;
    assign dbus_wdata_o = ex_wdata_i;

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            issued_q   <= 1'b0;
            wb_valid_q <= 1'b0;
            wb_we_q    <= 1'b0;
        end else begin
            if (dbus_gnt_i)
                issued_q <= 1'b1;
            else if (dbus_rvalid_i)
                issued_q <= 1'b0;
            wb_valid_q <= done;
            wb_we_q    <= done && writes_rd && ex_rd_i != '0;
        end
    end

    // ==================================================
    // retire register
    // ==================================================
    always_ff @(posedge clk) begin
        if (done) begin
            wb_wnum_q <= ex_rd_i;
            wb_pc_q   <= ex_pc_i;
            wb_inst_q <= ex_inst_i;
            case (ex_op_i)
                OP_LD:   wb_wdata_q <= dbus_rdata_i;
                OP_ST:   wb_wdata_q <= ex_wdata_i;
                default: wb_wdata_q <= ex_result_i;
            endcase
        end
    end

    assign rf_we_o    = wb_we_q;
    assign rf_wnum_o  = wb_wnum_q;
    assign rf_wdata_o = wb_wdata_q;

    assign debug_wb_valid_o = wb_valid_q;
    assign debug_wb_we_o    = wb_we_q;
    assign debug_wb_pc_o    = wb_pc_q;
    assign debug_wb_wnum_o  = wb_wnum_q;
    assign debug_wb_wdata_o = wb_wdata_q;
    assign debug_wb_inst_o  = wb_inst_q;

endmodule

`default_nettype wire

//--- source/bus_arbiter.sv
`timescale 1ns/1ps
`default_nettype none

module bus_arbiter (
    input  wire logic           clk,
    input  wire logic           rst_n_i,
    // instruction port
    input  wire logic           ibus_req_i,
    input  wire cpu_pkg::word_t ibus_addr_i,
    output logic                ibus_gnt_o,
    output logic                ibus_rvalid_o,
    // data port
    input  wire logic           dbus_req_i,
    input  wire logic           dbus_we_i,
    input  wire cpu_pkg::word_t dbus_addr_i,
    input  wire cpu_pkg::word_t dbus_wdata_i,
    output logic                dbus_gnt_o,
    output logic                dbus_rvalid_o,
    output cpu_pkg::word_t      rdata_o,
    // external memory bus
    output logic                mem_req_o,
    output logic                mem_we_o,
    output cpu_pkg::word_t      mem_addr_o,
    output cpu_pkg::word_t      mem_wdata_o,
    input  wire logic           mem_ready_i,
    input  wire logic           mem_rvalid_i,
    input  wire cpu_pkg::word_t mem_rdata_i
);

    logic busy_q;
    logic lock_q;
    logic owner_q;
    logic sel_data;
    logic accept;

    // data first, but a request already on the bus keeps its port
    assign sel_data = lock_q ? owner_q : dbus_req_i;

    assign mem_req_o   = !busy_q && (ibus_req_i || dbus_req_i);
    assign mem_we_o    = sel_data && dbus_we_i;
    assign mem_addr_o  = sel_data ? dbus_addr_i : ibus_addr_i;
    assign mem_wdata_o = dbus_wdata_i;
    assign accept      = mem_req_o && mem_ready_i;

    assign ibus_gnt_o = accept && !sel_data;
    assign dbus_gnt_o = accept && sel_data;

    assign ibus_rvalid_o = busy_q && mem_rvalid_i && !owner_q;
    assign dbus_rvalid_o = busy_q && mem_rvalid_i && owner_q;
    assign rdata_o       = mem_rdata_i;

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            busy_q  <= 1'b0;
            lock_q  <= 1'b0;
            owner_q <= 1'b0;
        end else if (busy_q) begin
            if (mem_rvalid_i)
                busy_q <= 1'b0;
        end else if (mem_req_o) begin
            owner_q <= sel_data;
            busy_q  <= mem_ready_i;
            lock_q  <= !mem_ready_i;
        end
    end

endmodule

`default_nettype wire

//--- source/cpu_top.sv
`timescale 1ns/1ps
`default_nettype none

module cpu_top #(
    parameter cpu_pkg::word_t RESET_PC = '0
) (
    input  wire logic           clk,
    input  wire logic           rst_n_i,
    // external memory bus
    output logic                mem_req_o,
    output logic                mem_we_o,
    output cpu_pkg::word_t      mem_addr_o,
    output cpu_pkg::word_t      mem_wdata_o,
    input  wire logic           mem_ready_i,
    input  wire logic           mem_rvalid_i,
    input  wire cpu_pkg::word_t mem_rdata_i,
    // debug writeback
    output logic                debug_wb_valid_o,
    output logic                debug_wb_we_o,
    output cpu_pkg::word_t      debug_wb_pc_o,
    output cpu_pkg::reg_idx_t   debug_wb_wnum_o,
    output cpu_pkg::word_t      debug_wb_wdata_o,
    output cpu_pkg::word_t      debug_wb_inst_o
);

    import cpu_pkg::*;

    // bus ports
    logic     ibus_req, ibus_gnt, ibus_rvalid;
    logic     dbus_req, dbus_we, dbus_gnt, dbus_rvalid;
    word_t    ibus_addr, dbus_addr, dbus_wdata, bus_rdata;

    // fetch to execute
    logic     if_valid, ex_ready;
    word_t    if_inst, if_pc;

    // register file
    reg_idx_t ra, rb, rc, rf_wnum;
    word_t    ra_data, rb_data, rc_data, rf_wdata;
    logic     rf_we;

    // memory stage
    logic     mem_busy, mem_dst_valid, ex_valid;
    reg_idx_t mem_dst, ex_rd;
    op_e      ex_op;
    word_t    ex_result, ex_wdata, ex_pc, ex_inst;

    reg_file u_reg_file (
        .clk, .rst_n_i,
        .ra_i(ra), .rb_i(rb), .rc_i(rc),
        .ra_data_o(ra_data), .rb_data_o(rb_data), .rc_data_o(rc_data),
        .we_i(rf_we), .wnum_i(rf_wnum), .wdata_i(rf_wdata)
    );

    fetch_unit #(
        .RESET_PC(RESET_PC)
    ) u_fetch_unit (
        .clk, .rst_n_i,
        .ibus_req_o(ibus_req), .ibus_addr_o(ibus_addr),
        .ibus_gnt_i(ibus_gnt), .ibus_rvalid_i(ibus_rvalid), .ibus_rdata_i(bus_rdata),
        .ex_ready_i(ex_ready),
        .if_valid_o(if_valid), .if_inst_o(if_inst), .if_pc_o(if_pc)
    );

    exec_unit u_exec_unit (
        .clk, .rst_n_i,
        .if_valid_i(if_valid), .if_inst_i(if_inst), .if_pc_i(if_pc),
        .ex_ready_o(ex_ready),
        .ra_o(ra), .rb_o(rb), .rc_o(rc),
        .ra_data_i(ra_data), .rb_data_i(rb_data), .rc_data_i(rc_data),
        .mem_busy_i(mem_busy), .mem_dst_valid_i(mem_dst_valid), .mem_dst_i(mem_dst),
        .ex_valid_o(ex_valid), .ex_op_o(ex_op), .ex_rd_o(ex_rd),
        .ex_result_o(ex_result), .ex_wdata_o(ex_wdata),
        .ex_pc_o(ex_pc), .ex_inst_o(ex_inst)
    );

    mem_unit u_mem_unit (
        .clk, .rst_n_i,
        .ex_valid_i(ex_valid), .ex_op_i(ex_op), .ex_rd_i(ex_rd),
        .ex_result_i(ex_result), .ex_wdata_i(ex_wdata),
        .ex_pc_i(ex_pc), .ex_inst_i(ex_inst),
        .mem_busy_o(mem_busy), .mem_dst_valid_o(mem_dst_valid), .mem_dst_o(mem_dst),
        .dbus_req_o(dbus_req), .dbus_we_o(dbus_we),
        .dbus_addr_o(dbus_addr), .dbus_wdata_o(dbus_wdata),
        .dbus_gnt_i(dbus_gnt), .dbus_rvalid_i(dbus_rvalid), .dbus_rdata_i(bus_rdata),
        .rf_we_o(rf_we), .rf_wnum_o(rf_wnum), .rf_wdata_o(rf_wdata),
        .debug_wb_valid_o, .debug_wb_we_o, .debug_wb_pc_o,
        .debug_wb_wnum_o, .debug_wb_wdata_o, .debug_wb_inst_o
    );

    // shared memory bus
    bus_arbiter u_bus_arbiter (
        .clk, .rst_n_i,
        .ibus_req_i(ibus_req), .ibus_addr_i(ibus_addr),
        .ibus_gnt_o(ibus_gnt), .ibus_rvalid_o(ibus_rvalid),
        .dbus_req_i(dbus_req), .dbus_we_i(dbus_we),
        .dbus_addr_i(dbus_addr), .dbus_wdata_i(dbus_wdata),
        .dbus_gnt_o(dbus_gnt), .dbus_rvalid_o(dbus_rvalid),
        .rdata_o(bus_rdata),
        .mem_req_o, .mem_we_o, .mem_addr_o, .mem_wdata_o,
        .mem_ready_i, .mem_rvalid_i, .mem_rdata_i
    );

endmodule

`default_nettype wire

//--- sim/cpu_asserts.sv
`timescale 1ns/1ps
`default_nettype none

module cpu_asserts #(
    parameter cpu_pkg::word_t RESET_PC = '0
) (
    input wire logic           clk,
    input wire logic           rst_n_i,
    input wire logic           mem_req_o,
    input wire logic           mem_we_o,
    input wire cpu_pkg::word_t mem_addr_o,
    input wire cpu_pkg::word_t mem_wdata_o,
    input wire logic           mem_ready_i,
    input wire logic           mem_rvalid_i,
    input wire logic           debug_wb_valid_o,
    input wire logic           debug_wb_we_o
);

    int unsigned fail_count = 0;

    logic in_reset_q;
    logic first_fetch_q;
    logic outstanding_q;

    // tracks the one bus transaction that may be open
    always_ff @(posedge clk) begin
        in_reset_q <= !rst_n_i;
        if (!rst_n_i) begin
            first_fetch_q <= 1'b1;
            outstanding_q <= 1'b0;
        end else begin
            if (mem_req_o)
                first_fetch_q <= 1'b0;
            if (mem_req_o && mem_ready_i)
                outstanding_q <= 1'b1;
            else if (mem_rvalid_i)
                outstanding_q <= 1'b0;
        end
    end

    // ==================================================
    // reset
    // ==================================================
    a_reset_quiet: assert property (@(posedge clk)
        in_reset_q |-> !mem_req_o && !debug_wb_valid_o && !debug_wb_we_o)
        else begin
            fail_count++;
            $error("bus request or retire seen during or right after reset");
        end

    a_first_fetch_pc: assert property (@(posedge clk) disable iff (!rst_n_i)
        first_fetch_q && mem_req_o |-> mem_addr_o == RESET_PC)
        else begin
            fail_count++;
            $error("first fetch address 0x%h differs from the reset pc", mem_addr_o);
        end

    // ==================================================
    // bus protocol
    // ==================================================
    a_req_stable: assert property (@(posedge clk) disable iff (!rst_n_i)
        mem_req_o && !mem_ready_i |=> mem_req_o && $stable(mem_we_o)
            && $stable(mem_addr_o) && (!mem_we_o || $stable(mem_wdata_o)))
        else begin
            fail_count++;
            $error("request dropped or changed before it was accepted");
        end

    a_single_outstanding: assert property (@(posedge clk) disable iff (!rst_n_i)
        outstanding_q |-> !mem_req_o)
        else begin
            fail_count++;
            $error("new request raised before the open transaction got its response");
        end

    a_we_with_valid: assert property (@(posedge clk) disable iff (!rst_n_i)
        debug_wb_we_o |-> debug_wb_valid_o)
        else begin
            fail_count++;
            $error("debug write enable without a retire");
        end

endmodule

bind cpu_top cpu_asserts #(.RESET_PC(RESET_PC)) cpu_asserts_i (.*);

`default_nettype wire

//--- sim/cpu_tb.sv
`timescale 1ns/1ps
`default_nettype none

module cpu_tb;

    import cpu_pkg::*;

    localparam word_t RESET_PC   = 32'h100;
    localparam int    NUM_INST   = 64;
    localparam int    MEM_WORDS  = 1024;
    localparam int    DATA_BASE  = 'h800;
    localparam int    DATA_WORDS = 16;
    // two bus transactions per instruction, each up to about 20 cycles
    localparam int    TIMEOUT_CYCLES = NUM_INST * 45 + 120;

    logic     clk;
    logic     rst_n_i;
    logic     mem_req_o;
    logic     mem_we_o;
    word_t    mem_addr_o;
    word_t    mem_wdata_o;
    logic     mem_ready_i;
    logic     mem_rvalid_i;
    word_t    mem_rdata_i;
    logic     debug_wb_valid_o;
    logic     debug_wb_we_o;
    word_t    debug_wb_pc_o;
    reg_idx_t debug_wb_wnum_o;
    word_t    debug_wb_wdata_o;
    word_t    debug_wb_inst_o;

    word_t       mem [MEM_WORDS];
    word_t       gold_mem [MEM_WORDS];
    op_e         p_op [NUM_INST];
    reg_idx_t    p_rd [NUM_INST];
    reg_idx_t    p_rj [NUM_INST];
    reg_idx_t    p_rk [NUM_INST];
    logic [11:0] p_imm [NUM_INST];
    word_t       exp_pc [NUM_INST];
    word_t       exp_inst [NUM_INST];
    logic        exp_we [NUM_INST];
    word_t       exp_wdata [NUM_INST];
    word_t       st_addr_q [$];
    word_t       st_data_q [$];

    int    errors;
    int    retired;
    int    cycles;
    logic  pending;
    int    resp_wait;
    word_t resp_data;

    cpu_top #(.RESET_PC(RESET_PC)) cpu_top_i (.*);

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    function automatic word_t encode_inst(input op_e op, input reg_idx_t rd, input reg_idx_t rj,
                                          input reg_idx_t rk, input logic [11:0] imm);
        word_t w;
        case (op)
            OP_ADD:  w = {OPC_ADD_W, rk, rj, rd};
            OP_ADDI: w = {OPC_ADDI_W, imm, rj, rd};
            OP_LD:   w = {OPC_LD_W, imm, rj, rd};
            OP_ST:   w = {OPC_ST_W, imm, rj, rd};
            default: w = {OPC_ADDI_W, 22'h0};
        endcase
        return w;
    endfunction

    task automatic report_mismatch(input string name, input word_t exp_v, input word_t got_v);
        errors++;
        $display("FAILED %s: expected 0x%h, got 0x%h at %0t", name, exp_v, got_v, $time);
    endtask

    // ==================================================
    // program and golden model
    // ==================================================
    task automatic gen_program();
        logic [11:0] offs [$];
        reg_idx_t    last_dst;
        int          sel;
        // preload r2..r7, then r1 = 0x400 + 0x400
        for (int i = 0; i < 6; i++) begin
            p_op[i]  = OP_ADDI;
            p_rd[i]  = reg_idx_t'(i + 2);
            p_rj[i]  = '0;
            p_rk[i]  = '0;
            p_imm[i] = 12'($urandom);
        end
        p_op[6] = OP_ADDI;
        p_rd[6] = 5'd1;
        p_rj[6] = '0;
        p_rk[6] = '0;
        p_imm[6] = 12'h400;
        p_op[7] = OP_ADD;
        p_rd[7] = 5'd1;
        p_rj[7] = 5'd1;
        p_rk[7] = 5'd1;
        p_imm[7] = '0;
        last_dst = 5'd1;
        for (int i = 8; i < NUM_INST; i++) begin
            sel      = int'($urandom % 8);
            p_rj[i]  = reg_idx_t'($urandom % 8);
            p_rk[i]  = reg_idx_t'($urandom % 8);
            p_rd[i]  = ($urandom % 8 == 0) ? 5'd0 : reg_idx_t'(2 + $urandom % 6);
            p_imm[i] = 12'($urandom);
            if ($urandom % 3 == 0)
                p_rj[i] = last_dst;
            if (sel >= 6 && offs.size() == 0)
                sel = 4;
            if (sel < 2) begin
                p_op[i] = OP_ADD;
            end else if (sel < 4) begin
                p_op[i] = OP_ADDI;
            end else if (sel < 6) begin
                p_op[i]  = OP_ST;
                p_rj[i]  = 5'd1;
                p_imm[i] = 12'(4 * ($urandom % DATA_WORDS));
                if ($urandom % 2 == 0)
                    p_rd[i] = last_dst;
                offs.push_back(p_imm[i]);
            end else begin
                p_op[i]  = OP_LD;
                p_rj[i]  = 5'd1;
                p_imm[i] = offs[$urandom % offs.size()];
            end
            if (p_op[i] != OP_ST)
                last_dst = p_rd[i];
        end
        // padding nops carry their own word index
        for (int a = 0; a < MEM_WORDS; a++)
            mem[a] = encode_inst(OP_ADDI, '0, '0, '0, 12'(a));
        for (int i = 0; i < NUM_INST; i++)
            mem[RESET_PC[11:2] + i] = encode_inst(p_op[i], p_rd[i], p_rj[i], p_rk[i], p_imm[i]);
    endtask

    task automatic run_golden();
        word_t regs [32];
        word_t addr;
        word_t val;
        for (int r = 0; r < 32; r++)
            regs[r] = '0;
        gold_mem = mem;
        for (int i = 0; i < NUM_INST; i++) begin
            addr = regs[p_rj[i]] + {{20{p_imm[i][11]}}, p_imm[i]};
            val  = '0;
            case (p_op[i])
                OP_ADD:  val = regs[p_rj[i]] + regs[p_rk[i]];
                OP_ADDI: val = addr;
                OP_LD:   val = gold_mem[addr[11:2]];
                default: begin
                    gold_mem[addr[11:2]] = regs[p_rd[i]];
                    st_addr_q.push_back(addr);
                    st_data_q.push_back(regs[p_rd[i]]);
                end
            endcase
            exp_pc[i]    = RESET_PC + word_t'(4 * i);
            exp_inst[i]  = encode_inst(p_op[i], p_rd[i], p_rj[i], p_rk[i], p_imm[i]);
            exp_we[i]    = (p_op[i] != OP_ST) && (p_rd[i] != '0);
            exp_wdata[i] = val;
            if (exp_we[i])
                regs[p_rd[i]] = val;
        end
    endtask

    // ==================================================
    // memory model and checks
    // ==================================================
    task automatic check_store(input word_t addr, input word_t data);
        if (st_addr_q.size() == 0) begin
            errors++;
            $display("store to 0x%h that the program does not contain", addr);
        end else begin
            assert (addr == st_addr_q[0]) else report_mismatch("mem_addr_o", st_addr_q[0], addr);
            assert (data == st_data_q[0]) else report_mismatch("mem_wdata_o", st_data_q[0], data);
            void'(st_addr_q.pop_front());
            void'(st_data_q.pop_front());
        end
    endtask

    task automatic check_retire(input int idx);
        word_t pc_e;
        word_t inst_e;
        logic  we_e;
        if (idx < NUM_INST) begin
            pc_e   = exp_pc[idx];
            inst_e = exp_inst[idx];
            we_e   = exp_we[idx];
        end else begin
            pc_e   = RESET_PC + word_t'(4 * idx);
            inst_e = encode_inst(OP_ADDI, '0, '0, '0, 12'(pc_e[11:2]));
            we_e   = 1'b0;
        end
        assert (debug_wb_pc_o == pc_e) else report_mismatch("debug_wb_pc_o", pc_e, debug_wb_pc_o);
        assert (debug_wb_inst_o == inst_e)
            else report_mismatch("debug_wb_inst_o", inst_e, debug_wb_inst_o);
        assert (debug_wb_we_o == we_e)
            else report_mismatch("debug_wb_we_o", word_t'(we_e), word_t'(debug_wb_we_o));
        if (we_e) begin
            assert (debug_wb_wnum_o == p_rd[idx])
                else report_mismatch("debug_wb_wnum_o", word_t'(p_rd[idx]),
                                     word_t'(debug_wb_wnum_o));
            assert (debug_wb_wdata_o == exp_wdata[idx])
                else report_mismatch("debug_wb_wdata_o", exp_wdata[idx], debug_wb_wdata_o);
        end
    endtask

    // accept at the edge, drive ready and response 1 ns later
    always @(posedge clk) begin
        if (mem_rvalid_i)
            pending = 1'b0;
        if (rst_n_i && mem_req_o && mem_ready_i) begin
            pending   = 1'b1;
            resp_wait = int'(1 + $urandom % 6);
            resp_data = mem[mem_addr_o[11:2]];
            if (mem_we_o) begin
                check_store(mem_addr_o, mem_wdata_o);
                mem[mem_addr_o[11:2]] = mem_wdata_o;
            end
        end
        #1;
        mem_ready_i  = ($urandom % 4 != 0);
        mem_rvalid_i = 1'b0;
        mem_rdata_i  = $urandom;
        if (pending) begin
            resp_wait--;
            if (resp_wait == 0) begin
                mem_rvalid_i = 1'b1;
                mem_rdata_i  = resp_data;
            end
        end
    end

    always @(posedge clk) begin
        if (rst_n_i && debug_wb_valid_o) begin
            check_retire(retired);
            retired++;
        end
    end

    initial begin
        void'($urandom(11));
        rst_n_i      = 1'b0;
        mem_ready_i  = 1'b0;
        mem_rvalid_i = 1'b0;
        mem_rdata_i  = '0;
        errors       = 0;
        retired      = 0;
        cycles       = 0;
        pending      = 1'b0;
        gen_program();
        run_golden();
        repeat (8) @(posedge clk);
        #1 rst_n_i = 1'b1;
        while (retired < NUM_INST && cycles < TIMEOUT_CYCLES) begin
            @(negedge clk);
            cycles++;
        end
        if (retired < NUM_INST) begin
            errors++;
            $display("timeout: only %0d of %0d instructions retired in %0d cycles",
                     retired, NUM_INST, cycles);
        end else begin
            repeat (2) @(negedge clk);
            if (st_addr_q.size() != 0) begin
                errors++;
                $display("%0d stores of the program never reached memory", st_addr_q.size());
            end
            for (int k = DATA_BASE / 4; k < DATA_BASE / 4 + DATA_WORDS; k++) begin
                assert (mem[k] == gold_mem[k])
                    else report_mismatch($sformatf("mem[0x%h]", k * 4), gold_mem[k], mem[k]);
            end
        end
        $display("errors: %0d in checks, %0d in protocol assertions",
                 errors, cpu_top_i.cpu_asserts_i.fail_count);
        if (errors == 0 && cpu_top_i.cpu_asserts_i.fail_count == 0)
            $display("Testbench passed");
        else
            $display("Testbench failed");
        $finish;
    end

endmodule

`default_nettype wire

//--- filelist.f
source/cpu_pkg.sv
source/reg_file.sv
source/fetch_unit.sv
source/exec_unit.sv
source/mem_unit.sv
source/bus_arbiter.sv
source/cpu_top.sv
sim/cpu_asserts.sv
sim/cpu_tb.sv
